/* logic/id_params.svh */
`ifndef ID_PARAMS_SVH
`define ID_PARAMS_SVH

`define ID_XLEN     32
`define ID_REG_AW   5
`define ID_ALU_OPS  12
`define ID_RA       5'd31

// major opcodes
`define ID_OP_SPECIAL  6'h00
`define ID_OP_REGIMM   6'h01
`define ID_OP_J        6'h02
`define ID_OP_JAL      6'h03
`define ID_OP_BEQ      6'h04
`define ID_OP_BNE      6'h05
`define ID_OP_BLEZ     6'h06
`define ID_OP_BGTZ     6'h07
`define ID_OP_ADDIU    6'h09
`define ID_OP_SLTI     6'h0a
`define ID_OP_SLTIU    6'h0b
`define ID_OP_ANDI     6'h0c
`define ID_OP_ORI      6'h0d
`define ID_OP_XORI     6'h0e
`define ID_OP_LUI      6'h0f
`define ID_OP_LW       6'h23
`define ID_OP_SW       6'h2b

// regimm rt field
`define ID_RT_BLTZ     5'h00
`define ID_RT_BGEZ     5'h01

// special function field
`define ID_FN_SLL      6'h00
`define ID_FN_SRL      6'h02
`define ID_FN_SRA      6'h03
`define ID_FN_SLLV     6'h04
`define ID_FN_SRLV     6'h06
`define ID_FN_SRAV     6'h07
`define ID_FN_JR       6'h08
`define ID_FN_ADDU     6'h21
`define ID_FN_SUBU     6'h23
`define ID_FN_AND      6'h24
`define ID_FN_OR       6'h25
`define ID_FN_XOR      6'h26
`define ID_FN_NOR      6'h27
`define ID_FN_SLT      6'h2a
`define ID_FN_SLTU     6'h2b

`endif

/* logic/id_pkg.sv */
`include "id_params.svh"

package id_pkg;

    // one-hot with op_add in bit 0
    typedef struct packed {
        logic op_lui;
        logic op_sra;
        logic op_srl;
        logic op_sll;
        logic op_xor;
        logic op_or;
        logic op_nor;
        logic op_and;
        logic op_sltu;
        logic op_slt;
        logic op_sub;
        logic op_add;
    } alu_op_t;

    typedef struct packed {
        logic [`ID_XLEN-1:0] pc;
        logic [`ID_XLEN-1:0] inst;
    } fs_to_ds_t;

    typedef struct packed {
        logic                  we;
        logic [`ID_REG_AW-1:0] waddr;
        logic [`ID_XLEN-1:0]   wdata;
    } wb_to_rf_t;

    // dest is zero when the stage writes nothing
    typedef struct packed {
        logic [`ID_REG_AW-1:0] dest;
        logic [`ID_XLEN-1:0]   data;
        logic                  is_load;
    } fwd_src_t;

    typedef struct packed {
        logic beq;
        logic bne;
        logic bgez;
        logic bgtz;
        logic blez;
        logic bltz;
        logic j;
        logic jal;
        logic jr;
    } br_kind_t;

    typedef struct packed {
        alu_op_t               alu_op;
        logic                  load_op;
        logic                  mem_we;
        logic                  gr_we;
        logic                  src1_is_sa;
        logic                  src1_is_pc;
        logic                  src2_is_imm;
        logic                  src2_is_imm_zero;
        logic                  src2_is_8;
        logic [`ID_REG_AW-1:0] dest;
        logic [15:0]           imm;
        logic                  rs_used;
        logic                  rt_used;
        br_kind_t              br;
        logic                  ri;
    } ds_ctrl_t;

    typedef struct packed {
        alu_op_t               alu_op;
        logic                  load_op;
        logic                  src1_is_sa;
        logic                  src1_is_pc;
        logic                  src2_is_imm;
        logic                  src2_is_imm_zero;
        logic                  src2_is_8;
        logic                  gr_we;
        logic                  mem_we;
        logic [`ID_REG_AW-1:0] dest;
        logic [15:0]           imm;
        logic                  ri;
        logic [`ID_XLEN-1:0]   rs_value;
        logic [`ID_XLEN-1:0]   rt_value;
        logic [`ID_XLEN-1:0]   pc;
    } ds_to_es_t;

    typedef struct packed {
        logic                is_branch;
        logic                stall;
        logic                taken;
        logic [`ID_XLEN-1:0] target;
    } br_bus_t;

endpackage

/* logic/ds_latch.sv */
`timescale 1ns/1ps

module ds_latch
    import id_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      flush,
    input  logic      fs_to_ds_valid,
    input  fs_to_ds_t fs_to_ds,
    input  logic      ready_go,
    input  logic      es_allowin,
    output logic      ds_allowin,
    output logic      ds_valid,
    output fs_to_ds_t ds
);

    assign ds_allowin = !ds_valid || (ready_go && es_allowin);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    // payload only moves on an accepted transfer
    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds <= fs_to_ds;
        end
    end

endmodule

/* logic/inst_decode.sv */
`timescale 1ns/1ps
`include "id_params.svh"

module inst_decode
    import id_pkg::*;
(
    input  logic [`ID_XLEN-1:0] inst,
    output ds_ctrl_t            ctrl
);

    logic [5:0] op;
    logic [5:0] fn;
    logic [`ID_REG_AW-1:0] rs, rt, rd, sa;
    logic special, r_fmt, sh_fmt;
    logic inst_addu, inst_subu, inst_slt, inst_sltu, inst_and, inst_or, inst_xor, inst_nor;
    logic inst_sll, inst_srl, inst_sra, inst_sllv, inst_srlv, inst_srav;
    logic inst_addiu, inst_slti, inst_sltiu, inst_andi, inst_ori, inst_xori, inst_lui;
    logic inst_lw, inst_sw;
    logic inst_beq, inst_bne, inst_bgez, inst_bgtz, inst_blez, inst_bltz;
    logic inst_j, inst_jal, inst_jr;
    logic dst_is_rt, no_dest, is_br;
    logic [`ID_ALU_OPS-1:0] alu_bits;

    assign op = inst[31:26];
    assign rs = inst[25:21];
    assign rt = inst[20:16];
    assign rd = inst[15:11];
    assign sa = inst[10:6];
    assign fn = inst[5:0];

    assign special = (op == `ID_OP_SPECIAL);
    // register forms need sa zero and constant shifts need rs zero
    assign r_fmt   = special && (sa == '0);
    assign sh_fmt  = special && (rs == '0);

    assign inst_addu  = r_fmt && (fn == `ID_FN_ADDU);
    assign inst_subu  = r_fmt && (fn == `ID_FN_SUBU);
    assign inst_slt   = r_fmt && (fn == `ID_FN_SLT);
    assign inst_sltu  = r_fmt && (fn == `ID_FN_SLTU);
    assign inst_and   = r_fmt && (fn == `ID_FN_AND);
    assign inst_or    = r_fmt && (fn == `ID_FN_OR);
    assign inst_xor   = r_fmt && (fn == `ID_FN_XOR);
    assign inst_nor   = r_fmt && (fn == `ID_FN_NOR);
    assign inst_sllv  = r_fmt && (fn == `ID_FN_SLLV);
    assign inst_srlv  = r_fmt && (fn == `ID_FN_SRLV);
    assign inst_srav  = r_fmt && (fn == `ID_FN_SRAV);
    assign inst_sll   = sh_fmt && (fn == `ID_FN_SLL);
    assign inst_srl   = sh_fmt && (fn == `ID_FN_SRL);
    assign inst_sra   = sh_fmt && (fn == `ID_FN_SRA);
    assign inst_jr    = r_fmt && (fn == `ID_FN_JR) && (rt == '0) && (rd == '0);

    assign inst_addiu = (op == `ID_OP_ADDIU);
    assign inst_slti  = (op == `ID_OP_SLTI);
    assign inst_sltiu = (op == `ID_OP_SLTIU);
    assign inst_andi  = (op == `ID_OP_ANDI);
    assign inst_ori   = (op == `ID_OP_ORI);
    assign inst_xori  = (op == `ID_OP_XORI);
    assign inst_lui   = (op == `ID_OP_LUI) && (rs == '0);
    assign inst_lw    = (op == `ID_OP_LW);
    assign inst_sw    = (op == `ID_OP_SW);
    assign inst_beq   = (op == `ID_OP_BEQ);
    assign inst_bne   = (op == `ID_OP_BNE);
    assign inst_bgez  = (op == `ID_OP_REGIMM) && (rt == `ID_RT_BGEZ);
    assign inst_bltz  = (op == `ID_OP_REGIMM) && (rt == `ID_RT_BLTZ);
    assign inst_bgtz  = (op == `ID_OP_BGTZ) && (rt == '0);
    assign inst_blez  = (op == `ID_OP_BLEZ) && (rt == '0);
    assign inst_j     = (op == `ID_OP_J);
    assign inst_jal   = (op == `ID_OP_JAL);

    // jal computes its link value pc + 8 on the adder
    assign alu_bits = {
        inst_lui,
        inst_sra | inst_srav,
        inst_srl | inst_srlv,
        inst_sll | inst_sllv,
        inst_xor | inst_xori,
        inst_or | inst_ori,
        inst_nor,
        inst_and | inst_andi,
        inst_sltu | inst_sltiu,
        inst_slt | inst_slti,
        inst_subu,
        inst_addu | inst_addiu | inst_lw | inst_sw | inst_jal
    };

    assign ctrl.br = '{beq: inst_beq, bne: inst_bne, bgez: inst_bgez, bgtz: inst_bgtz,
                       blez: inst_blez, bltz: inst_bltz, j: inst_j, jal: inst_jal,
                       jr: inst_jr};
    assign is_br   = inst_beq | inst_bne | inst_bgez | inst_bgtz | inst_blez | inst_bltz;

    assign dst_is_rt = inst_addiu | inst_slti | inst_sltiu | inst_andi | inst_ori
                     | inst_xori | inst_lui | inst_lw;
    assign no_dest   = inst_sw | is_br | inst_j | inst_jr;

    assign ctrl.alu_op           = alu_op_t'(alu_bits);
    assign ctrl.load_op          = inst_lw;
    assign ctrl.mem_we           = inst_sw;
    assign ctrl.ri               = !((|alu_bits) || is_br || inst_j || inst_jr);
    assign ctrl.gr_we            = !ctrl.ri && !no_dest;
    assign ctrl.src1_is_sa       = inst_sll | inst_srl | inst_sra;
    assign ctrl.src1_is_pc       = inst_jal;
    assign ctrl.src2_is_imm      = inst_addiu | inst_slti | inst_sltiu | inst_lui
                                 | inst_lw | inst_sw;
    assign ctrl.src2_is_imm_zero = inst_andi | inst_ori | inst_xori;
    assign ctrl.src2_is_8        = inst_jal;
    assign ctrl.imm              = inst[15:0];

    assign ctrl.dest = inst_jal  ? `ID_RA :
                       dst_is_rt ? rt     :
                       no_dest   ? '0     : rd;

    assign ctrl.rs_used = !ctrl.ri && !(ctrl.src1_is_sa || inst_lui || inst_j || inst_jal);
    assign ctrl.rt_used = (r_fmt && (|alu_bits)) || ctrl.src1_is_sa
                        || inst_beq || inst_bne || inst_sw;

endmodule

/* logic/regfile.sv */
`timescale 1ns/1ps
`include "id_params.svh"

module regfile
    import id_pkg::*;
(
    input  logic                  clk,
    input  logic [`ID_REG_AW-1:0] raddr1,
    input  logic [`ID_REG_AW-1:0] raddr2,
    output logic [`ID_XLEN-1:0]   rdata1,
    output logic [`ID_XLEN-1:0]   rdata2,
    input  wb_to_rf_t             wb
);

    logic [`ID_XLEN-1:0] regs [2**`ID_REG_AW];

    always_ff @(posedge clk) begin
        if (wb.we && (wb.waddr != '0)) begin
            regs[wb.waddr] <= wb.wdata;
        end
    end

    // r0 is hardwired
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* logic/operand_fetch.sv */
`timescale 1ns/1ps
`include "id_params.svh"

module operand_fetch
    import id_pkg::*;
(
    input  logic                clk,
    input  logic [`ID_XLEN-1:0] inst,
    input  wb_to_rf_t           wb,
    input  fwd_src_t            es_fwd,
    input  fwd_src_t            ms_fwd,
    input  fwd_src_t            ws_fwd,
    input  logic                data_sram_data_ok,
    output logic [`ID_XLEN-1:0] rs_value,
    output logic [`ID_XLEN-1:0] rt_value,
    output logic                rs_load_busy,
    output logic                rt_load_busy
);

    logic [`ID_REG_AW-1:0] rs, rt;
    logic [`ID_XLEN-1:0]   rf_rdata1, rf_rdata2;

    // youngest producer wins
    function automatic logic [`ID_XLEN-1:0] fwd_value(input logic [`ID_REG_AW-1:0] src,
                                                      input logic [`ID_XLEN-1:0] rf_data);
        if (src == '0) return rf_data;
        if (src == es_fwd.dest) return es_fwd.data;
        if (src == ms_fwd.dest) return ms_fwd.data;
        if (src == ws_fwd.dest) return ws_fwd.data;
        return rf_data;
    endfunction

    // a load in write-back already has its data
    function automatic logic load_busy(input logic [`ID_REG_AW-1:0] src);
        if (src == '0) return 1'b0;
        if (src == es_fwd.dest) return es_fwd.is_load;
        if (src == ms_fwd.dest) return ms_fwd.is_load && !data_sram_data_ok;
        return 1'b0;
    endfunction

    assign rs = inst[25:21];
    assign rt = inst[20:16];

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rs),
        .raddr2 (rt),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wb     (wb)
    );

    always_comb begin
        rs_value     = fwd_value(rs, rf_rdata1);
        rt_value     = fwd_value(rt, rf_rdata2);
        rs_load_busy = load_busy(rs);
        rt_load_busy = load_busy(rt);
    end

endmodule

/* logic/issue_control.sv */
`timescale 1ns/1ps
`include "id_params.svh"

module issue_control
    import id_pkg::*;
(
    input  logic                ds_valid,
    input  fs_to_ds_t           ds,
    input  ds_ctrl_t            ctrl,
    input  logic [`ID_XLEN-1:0] rs_value,
    input  logic [`ID_XLEN-1:0] rt_value,
    input  logic                rs_load_busy,
    input  logic                rt_load_busy,
    output logic                ready_go,
    output logic                ds_to_es_valid,
    output ds_to_es_t           ds_to_es,
    output br_bus_t             br_bus
);

    logic                load_stall;
    logic                rs_eq_rt, rs_lt_zero, rs_gt_zero;
    logic                any_br, cond_br, taken_raw;
    logic [`ID_XLEN-1:0] pc_plus4;

    assign load_stall     = (ctrl.rs_used && rs_load_busy) || (ctrl.rt_used && rt_load_busy);
    assign ready_go       = !load_stall;
    assign ds_to_es_valid = ds_valid && ready_go;

    assign rs_eq_rt   = (rs_value == rt_value);
    assign rs_lt_zero = rs_value[`ID_XLEN-1];
    assign rs_gt_zero = !rs_lt_zero && (rs_value != '0);

    assign cond_br = ctrl.br.beq | ctrl.br.bne | ctrl.br.bgez | ctrl.br.bgtz
                   | ctrl.br.blez | ctrl.br.bltz;
    assign any_br  = cond_br | ctrl.br.j | ctrl.br.jal | ctrl.br.jr;

    assign taken_raw = (ctrl.br.beq && rs_eq_rt)
                     || (ctrl.br.bne && !rs_eq_rt)
                     || (ctrl.br.bgez && !rs_lt_zero)
                     || (ctrl.br.bgtz && rs_gt_zero)
                     || (ctrl.br.blez && !rs_gt_zero)
                     || (ctrl.br.bltz && rs_lt_zero)
                     || ctrl.br.j || ctrl.br.jal || ctrl.br.jr;

    assign pc_plus4 = ds.pc + `ID_XLEN'd4;

    assign br_bus.is_branch = any_br && ds_valid;
    assign br_bus.taken     = taken_raw && ds_valid;
    // fetch must not redirect on a stale operand
    assign br_bus.stall     = taken_raw && load_stall && ds_valid;
    assign br_bus.target    = cond_br    ? pc_plus4 + {{14{ctrl.imm[15]}}, ctrl.imm, 2'b00} :
                              ctrl.br.jr ? rs_value :
                                           {pc_plus4[31:28], ds.inst[25:0], 2'b00};

    assign ds_to_es.alu_op           = ctrl.alu_op;
    assign ds_to_es.load_op          = ctrl.load_op;
    assign ds_to_es.src1_is_sa       = ctrl.src1_is_sa;
    assign ds_to_es.src1_is_pc       = ctrl.src1_is_pc;
    assign ds_to_es.src2_is_imm      = ctrl.src2_is_imm;
    assign ds_to_es.src2_is_imm_zero = ctrl.src2_is_imm_zero;
    assign ds_to_es.src2_is_8        = ctrl.src2_is_8;
    assign ds_to_es.gr_we            = ctrl.gr_we;
    assign ds_to_es.mem_we           = ctrl.mem_we;
    assign ds_to_es.dest             = ctrl.dest;
    assign ds_to_es.imm              = ctrl.imm;
    assign ds_to_es.ri               = ctrl.ri;
    assign ds_to_es.rs_value         = rs_value;
    assign ds_to_es.rt_value         = rt_value;
    assign ds_to_es.pc               = ds.pc;

endmodule

/* logic/id_stage.sv */
`timescale 1ns/1ps

module id_stage
    import id_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      flush,
    input  logic      fs_to_ds_valid,
    input  fs_to_ds_t fs_to_ds,
    output logic      ds_allowin,
    input  logic      es_allowin,
    output logic      ds_to_es_valid,
    output ds_to_es_t ds_to_es,
    output br_bus_t   br_bus,
    input  wb_to_rf_t wb,
    input  fwd_src_t  es_fwd,
    input  fwd_src_t  ms_fwd,
    input  fwd_src_t  ws_fwd,
    input  logic      data_sram_data_ok
);

    logic      ds_valid;
    logic      ready_go;
    fs_to_ds_t ds;
    ds_ctrl_t  ctrl;
    logic [31:0] rs_value, rt_value;
    logic      rs_load_busy, rt_load_busy;

    ds_latch u_ds_latch (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds       (fs_to_ds),
        .ready_go       (ready_go),
        .es_allowin     (es_allowin),
        .ds_allowin     (ds_allowin),
        .ds_valid       (ds_valid),
        .ds             (ds)
    );

    inst_decode u_inst_decode (
        .inst (ds.inst),
        .ctrl (ctrl)
    );

    operand_fetch u_operand_fetch (
        .clk               (clk),
        .inst              (ds.inst),
        .wb                (wb),
        .es_fwd            (es_fwd),
        .ms_fwd            (ms_fwd),
        .ws_fwd            (ws_fwd),
        .data_sram_data_ok (data_sram_data_ok),
        .rs_value          (rs_value),
        .rt_value          (rt_value),
        .rs_load_busy      (rs_load_busy),
        .rt_load_busy      (rt_load_busy)
    );

    issue_control u_issue_control (
        .ds_valid       (ds_valid),
        .ds             (ds),
        .ctrl           (ctrl),
        .rs_value       (rs_value),
        .rt_value       (rt_value),
        .rs_load_busy   (rs_load_busy),
        .rt_load_busy   (rt_load_busy),
        .ready_go       (ready_go),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es       (ds_to_es),
        .br_bus         (br_bus)
    );

endmodule

/* dv/id_stage_tb.sv */
`timescale 1ns/1ps
`include "id_params.svh"

module id_stage_tb
    import id_pkg::*;
();

    // columns of one test data line
    localparam int C_INST = 0, C_PC = 1, C_WE = 2, C_WADDR = 3, C_WDATA = 4;
    localparam int C_ESD = 5, C_ESV = 6, C_ESL = 7, C_MSD = 8, C_MSV = 9, C_MSL = 10;
    localparam int C_WSD = 11, C_WSV = 12, C_STALL = 13, C_FLUSH = 14;
    localparam int C_ALU = 15, C_FLG = 16, C_DEST = 17, C_IMM = 18, C_RI = 19;
    localparam int C_RS = 20, C_RT = 21, C_BR = 22, C_TK = 23, C_TGT = 24;
    localparam int NCOL = 25;

    logic      clk = 1'b0;
    logic      reset, flush, fs_to_ds_valid, es_allowin, data_sram_data_ok;
    logic      ds_allowin, ds_to_es_valid;
    fs_to_ds_t fs_to_ds;
    ds_to_es_t ds_to_es;
    br_bus_t   br_bus;
    wb_to_rf_t wb;
    fwd_src_t  es_fwd, ms_fwd, ws_fwd;

    logic [31:0] vec [0:63][0:NCOL-1];
    int          nvec = 0;
    int          max_stall = 0;
    longint      limit_ns = 0;
    int          bundle_errs = 0;
    int          branch_errs = 0;
    int          other_errs = 0;

    id_stage uut (
        .clk               (clk),
        .reset             (reset),
        .flush             (flush),
        .fs_to_ds_valid    (fs_to_ds_valid),
        .fs_to_ds          (fs_to_ds),
        .ds_allowin        (ds_allowin),
        .es_allowin        (es_allowin),
        .ds_to_es_valid    (ds_to_es_valid),
        .ds_to_es          (ds_to_es),
        .br_bus            (br_bus),
        .wb                (wb),
        .es_fwd            (es_fwd),
        .ms_fwd            (ms_fwd),
        .ws_fwd            (ws_fwd),
        .data_sram_data_ok (data_sram_data_ok)
    );

    always #50 clk = ~clk;

    function automatic logic random_allowin();
        return ($urandom % 4) != 0;
    endfunction

    function automatic logic [7:0] flags_of(input ds_to_es_t b);
        return {b.load_op, b.src1_is_sa, b.src1_is_pc, b.src2_is_imm,
                b.src2_is_imm_zero, b.src2_is_8, b.gr_we, b.mem_we};
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp, inout int bad);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
            bad++;
        end
    endtask

    task automatic check_bundle(input ds_to_es_t got, input ds_to_es_t exp);
        int bad;
        bad = 0;
        check_field("alu_op", 32'(got.alu_op), 32'(exp.alu_op), bad);
        check_field("flags", 32'(flags_of(got)), 32'(flags_of(exp)), bad);
        check_field("dest", 32'(got.dest), 32'(exp.dest), bad);
        check_field("imm", 32'(got.imm), 32'(exp.imm), bad);
        check_field("ri", 32'(got.ri), 32'(exp.ri), bad);
        check_field("rs_value", got.rs_value, exp.rs_value, bad);
        check_field("rt_value", got.rt_value, exp.rt_value, bad);
        check_field("pc", got.pc, exp.pc, bad);
        bundle_errs += bad;
    endtask

    task automatic check_branch(input br_bus_t got, input br_bus_t exp);
        int bad;
        bad = 0;
        check_field("is_branch", 32'(got.is_branch), 32'(exp.is_branch), bad);
        check_field("br stall", 32'(got.stall), 32'(exp.stall), bad);
        check_field("taken", 32'(got.taken), 32'(exp.taken), bad);
        if (exp.is_branch) begin
            check_field("target", got.target, exp.target, bad);
        end
        branch_errs += bad;
    endtask

    task automatic load_vectors();
        int    fd;
        int    cnt;
        string line;
        fd = $fopen("dv/id_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open dv/id_testdata.txt");
            other_errs++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
                cnt = $sscanf(line,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    vec[nvec][0], vec[nvec][1], vec[nvec][2], vec[nvec][3], vec[nvec][4],
                    vec[nvec][5], vec[nvec][6], vec[nvec][7], vec[nvec][8], vec[nvec][9],
                    vec[nvec][10], vec[nvec][11], vec[nvec][12], vec[nvec][13],
                    vec[nvec][14], vec[nvec][15], vec[nvec][16], vec[nvec][17],
                    vec[nvec][18], vec[nvec][19], vec[nvec][20], vec[nvec][21],
                    vec[nvec][22], vec[nvec][23], vec[nvec][24]);
                if (cnt != NCOL) begin
                    $display("test data line %0d has %0d fields", nvec, cnt);
                    other_errs++;
                end else begin
                    if (int'(vec[nvec][C_STALL]) > max_stall) begin
                        max_stall = int'(vec[nvec][C_STALL]);
                    end
                    nvec++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_step(input int i);
        ds_to_es_t exp_b;
        br_bus_t   exp_br;
        int        stalls;
        bit        moved;
        exp_b = '0;
        exp_b.alu_op = alu_op_t'(vec[i][C_ALU][11:0]);
        {exp_b.load_op, exp_b.src1_is_sa, exp_b.src1_is_pc, exp_b.src2_is_imm,
         exp_b.src2_is_imm_zero, exp_b.src2_is_8, exp_b.gr_we, exp_b.mem_we} = vec[i][C_FLG][7:0];
        exp_b.dest = vec[i][C_DEST][4:0];
        exp_b.imm = vec[i][C_IMM][15:0];
        exp_b.ri = vec[i][C_RI][0];
        exp_b.rs_value = vec[i][C_RS];
        exp_b.rt_value = vec[i][C_RT];
        exp_b.pc = vec[i][C_PC];
        exp_br = '0;
        exp_br.is_branch = vec[i][C_BR][0];
        exp_br.taken = vec[i][C_TK][0];
        exp_br.target = vec[i][C_TGT];
        stalls = 0;
        moved = 1'b0;

        @(posedge clk);
        fs_to_ds_valid <= 1'b1;
        fs_to_ds <= '{pc: vec[i][C_PC], inst: vec[i][C_INST]};
        wb <= '{we: vec[i][C_WE][0], waddr: vec[i][C_WADDR][4:0], wdata: vec[i][C_WDATA]};
        es_fwd <= '{dest: vec[i][C_ESD][4:0], data: vec[i][C_ESV], is_load: vec[i][C_ESL][0]};
        ms_fwd <= '{dest: vec[i][C_MSD][4:0], data: vec[i][C_MSV], is_load: vec[i][C_MSL][0]};
        ws_fwd <= '{dest: vec[i][C_WSD][4:0], data: vec[i][C_WSV], is_load: 1'b0};
        data_sram_data_ok <= (vec[i][C_STALL] == 0);
        // hold execute off so the flush meets a waiting item
        es_allowin <= vec[i][C_FLUSH][0] ? 1'b0 : random_allowin();
        @(negedge clk);
        if (!ds_allowin) begin
            $display("stage refused the item of step %0d", i);
            other_errs++;
        end
        @(posedge clk);
        fs_to_ds_valid <= 1'b0;
        // fetch moves on while the held item stays
        fs_to_ds <= '{pc: ~vec[i][C_PC], inst: ~vec[i][C_INST]};
        wb.we <= 1'b0;
        if (vec[i][C_FLUSH][0]) begin
            flush <= 1'b1;
            @(posedge clk);
            flush <= 1'b0;
            @(negedge clk);
            if (ds_to_es_valid) begin
                $display("flushed item of step %0d still offered to execute", i);
                other_errs++;
            end
        end else begin
            while (!moved) begin
                @(negedge clk);
                if (ds_to_es_valid && es_allowin) begin
                    check_bundle(ds_to_es, exp_b);
                    exp_br.stall = 1'b0;
                    check_branch(br_bus, exp_br);
                    if (stalls != int'(vec[i][C_STALL])) begin
                        $display("step %0d stalled %0d cycles instead of %0d",
                                 i, stalls, vec[i][C_STALL]);
                        other_errs++;
                    end
                    moved = 1'b1;
                end else if (ds_to_es_valid) begin
                    // execute is blocking so the item must hold
                    if (ds_allowin) begin
                        $display("stage accepts input while execute blocks at step %0d", i);
                        other_errs++;
                    end
                    check_bundle(ds_to_es, exp_b);
                end else begin
                    exp_br.stall = exp_br.taken;
                    check_branch(br_bus, exp_br);
                    stalls++;
                end
                @(posedge clk);
                es_allowin <= random_allowin();
                if (stalls >= int'(vec[i][C_STALL])) begin
                    data_sram_data_ok <= 1'b1;
                end
            end
            @(negedge clk);
            if (ds_to_es_valid) begin
                $display("item of step %0d offered to execute twice", i);
                other_errs++;
            end
        end
    endtask

    initial begin
        wait (limit_ns != 0);
        #(limit_ns);
        $display("run did not finish within %0d ns, timed out", limit_ns);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        reset = 1'b1;
        flush = 1'b0;
        fs_to_ds_valid = 1'b0;
        fs_to_ds = '0;
        es_allowin = 1'b1;
        data_sram_data_ok = 1'b1;
        wb = '0;
        es_fwd = '0;
        ms_fwd = '0;
        ws_fwd = '0;
        void'($urandom(41));
        load_vectors();
        limit_ns = (longint'(nvec) * (max_stall + 20) + 20) * 100;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (ds_to_es_valid || br_bus.is_branch || br_bus.taken || br_bus.stall) begin
            $display("outputs active right after reset");
            other_errs++;
        end
        for (int i = 0; i < nvec; i++) begin
            run_step(i);
        end
        $display("errors: bundle %0d, branch %0d, other %0d",
                 bundle_errs, branch_errs, other_errs);
        if (bundle_errs + branch_errs + other_errs == 0 && nvec > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* dv/id_testdata.txt */
# inst pc | wb we waddr wdata | es dest data load | ms dest data load | ws dest data | stall flush
# expected: alu_op flags dest imm ri rs_value rt_value | is_branch taken target (all hex)
34001234 100 1 1 11 0 0 0 0 0 0 0 0 0 0 040 0a 00 1234 0 0 0 0 0 0
3c01abcd 104 1 2 22 0 0 0 0 0 0 0 0 0 0 800 12 01 abcd 0 0 11 0 0 0
00222821 108 1 3 fffffff0 0 0 0 0 0 0 0 0 0 0 001 02 05 2821 0 11 22 0 0 0
00413023 10c 1 4 11 0 0 0 0 0 0 0 0 0 0 002 02 06 3023 0 22 11 0 0 0
0062382a 110 1 0 dead 0 0 0 0 0 0 0 0 0 0 004 02 07 382a 0 fffffff0 22 0 0 0
2c640010 114 0 0 0 0 0 0 0 0 0 0 0 0 0 008 12 04 0010 0 fffffff0 11 0 0 0
00014824 118 0 0 0 0 0 0 0 0 0 0 0 0 0 010 02 09 4824 0 0 11 0 0 0
000250c0 11c 0 0 0 0 0 0 0 0 0 0 0 0 0 100 42 0a 50c0 0 0 22 0 0 0
00035903 120 0 0 0 0 0 0 0 0 0 0 0 0 0 400 42 0b 5903 0 0 fffffff0 0 0 0
3822ff00 124 0 0 0 0 0 0 0 0 0 0 0 0 0 080 0a 02 ff00 0 11 22 0 0 0
8c410008 128 0 0 0 0 0 0 0 0 0 0 0 0 0 001 92 01 0008 0 22 11 0 0 0
ac22fffc 12c 0 0 0 0 0 0 0 0 0 0 0 0 0 001 11 00 fffc 0 11 22 0 0 0
fc000000 130 0 0 0 0 0 0 0 0 0 0 0 0 0 000 00 00 0000 1 0 0 0 0 0
00222821 134 0 0 0 1 a1 0 1 b1 0 2 c2 0 0 001 02 05 2821 0 a1 c2 0 0 0
00222821 138 0 0 0 3 e3 0 2 b2 0 2 c2 0 0 001 02 05 2821 0 11 b2 0 0 0
00014824 13c 0 0 0 0 ee 0 0 0 0 0 ff 0 0 010 02 09 4824 0 0 11 0 0 0
10240010 200 0 0 0 0 0 0 4 11 1 0 0 3 0 000 00 00 0010 0 11 11 1 1 244
00222821 204 0 0 0 0 0 0 2 99 1 0 0 2 0 001 02 05 2821 0 11 99 0 0 0
1422fff8 300 0 0 0 0 0 0 0 0 0 0 0 0 0 000 00 00 fff8 0 11 22 1 1 2e4
04610004 400 0 0 0 0 0 0 0 0 0 0 0 0 0 000 00 00 0004 0 fffffff0 11 1 0 414
1c400004 410 0 0 0 0 0 0 0 0 0 0 0 0 0 000 00 00 0004 0 22 0 1 1 424
18000008 420 0 0 0 0 0 0 0 0 0 0 0 0 0 000 00 00 0008 0 0 0 1 1 444
04600002 430 0 0 0 0 0 0 0 0 0 0 0 0 0 000 00 00 0002 0 fffffff0 0 1 1 43c
08000040 500 0 0 0 0 0 0 0 0 0 0 0 0 0 000 00 00 0040 0 0 0 1 1 100
0c000080 504 0 0 0 0 0 0 0 0 0 0 0 0 0 001 26 1f 0080 0 0 0 1 1 200
00400008 508 0 0 0 0 0 0 0 0 0 0 0 0 0 000 00 00 0008 0 22 0 1 1 22
00222821 600 0 0 0 0 0 0 0 0 0 0 0 0 1 000 00 00 0000 0 0 0 0 0 0
00413023 604 0 0 0 0 0 0 0 0 0 0 0 0 0 002 02 06 3023 0 22 11 0 0 0

/* id_stage.f */
+incdir+logic
logic/id_pkg.sv
logic/ds_latch.sv
logic/inst_decode.sv
logic/regfile.sv
logic/operand_fetch.sv
logic/issue_control.sv
logic/id_stage.sv
dv/id_stage_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= id_stage_tb
FILELIST  ?= id_stage.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
